//--- hw/acc_alu.sv
`timescale 1ns/1ps
`default_nettype none

module acc_alu (
    input  acc_cpu_pkg::alu_op_e    op,
    input  acc_cpu_pkg::word_t      acc_val,
    input  acc_cpu_pkg::word_t      mem_val,
    input  acc_cpu_pkg::skip_cond_e skip_cond,
    output acc_cpu_pkg::word_t      result,
    output logic                    cond_met
);

    logic acc_neg;
    logic acc_zero;

    assign acc_neg  = acc_val[acc_cpu_pkg::WORD_W-1]; // Signed test on the top bit
    assign acc_zero = (acc_val == '0);

    always_comb begin
        case (op)
            acc_cpu_pkg::ALU_PASS_ACC: result = acc_val;
            acc_cpu_pkg::ALU_ZERO:     result = '0;        // CLEAR
            acc_cpu_pkg::ALU_PASS_MEM: result = mem_val;   // LOAD
            acc_cpu_pkg::ALU_ADD:      result = acc_val + mem_val; // Wraps at 16 bits
            acc_cpu_pkg::ALU_SUB:      result = acc_val - mem_val;
            acc_cpu_pkg::ALU_AND:      result = acc_val & mem_val;
            acc_cpu_pkg::ALU_OR:       result = acc_val | mem_val;
            acc_cpu_pkg::ALU_XOR:      result = acc_val ^ mem_val;
            acc_cpu_pkg::ALU_NOR:      result = ~(acc_val | mem_val);
            acc_cpu_pkg::ALU_NAND:     result = ~(acc_val & mem_val);
            acc_cpu_pkg::ALU_SHL:      result = {acc_val[14:0], 1'b0};
            acc_cpu_pkg::ALU_SHR:      result = {1'b0, acc_val[15:1]}; // Logical shift
            acc_cpu_pkg::ALU_ROL:      result = {acc_val[14:0], acc_val[15]};
            acc_cpu_pkg::ALU_ROR:      result = {acc_val[0], acc_val[15:1]};
            default:                   result = acc_val;
        endcase
    end

    // Skip test looks only at the accumulator
    always_comb begin
        case (skip_cond)
            acc_cpu_pkg::SKIP_NEG:  cond_met = acc_neg;
            acc_cpu_pkg::SKIP_ZERO: cond_met = acc_zero;
            acc_cpu_pkg::SKIP_POS:  cond_met = !acc_neg && !acc_zero; // Strictly positive
            default:                cond_met = 1'b0;
        endcase
    end

    // The control FSM must only ever hand over a listed operation
    always_comb begin
        assert #0 (op inside {[acc_cpu_pkg::ALU_PASS_ACC : acc_cpu_pkg::ALU_ROR]});
    end

endmodule

`default_nettype wire

//--- hw/acc_control.sv
`timescale 1ns/1ps
`default_nettype none

module acc_control (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    run,
    input  acc_cpu_pkg::dp_status_t status,
    output acc_cpu_pkg::ctrl_t      ctrl,
    output acc_cpu_pkg::skip_cond_e skip_cond,
    output logic                    store_valid,
    output logic                    halted,
    output logic                    illegal
);

    acc_cpu_pkg::cpu_state_e state;
    acc_cpu_pkg::cpu_state_e state_next;
    logic                    in_execute;
    logic                    stop_op;

    assign in_execute = (state == acc_cpu_pkg::ST_EXECUTE);
    assign stop_op    = (status.opcode == acc_cpu_pkg::OP_HALT) ||
                        (status.opcode == acc_cpu_pkg::OP_ILLEGAL);

    always_comb begin
        state_next = state;
        case (state)
            acc_cpu_pkg::ST_IDLE:    if (run) state_next = acc_cpu_pkg::ST_FETCH;
            acc_cpu_pkg::ST_FETCH:   state_next = acc_cpu_pkg::ST_DECODE;
            acc_cpu_pkg::ST_DECODE:  state_next = acc_cpu_pkg::ST_OPERAND;
            acc_cpu_pkg::ST_OPERAND: state_next = acc_cpu_pkg::ST_EXECUTE;
            acc_cpu_pkg::ST_EXECUTE: begin
                state_next = stop_op ? acc_cpu_pkg::ST_HALTED : acc_cpu_pkg::ST_FETCH;
            end
            acc_cpu_pkg::ST_HALTED:  state_next = acc_cpu_pkg::ST_HALTED; // Until reset
            default:                 state_next = acc_cpu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= acc_cpu_pkg::ST_IDLE;
            illegal <= 1'b0;
        end else begin
            state <= state_next;
            if (in_execute && status.opcode == acc_cpu_pkg::OP_ILLEGAL) begin
                illegal <= 1'b1; // Rises together with halted
            end
        end
    end

    // Condition code sits in the operand field of SKIP
    always_comb begin
        case (status.operand)
            12'd0:   skip_cond = acc_cpu_pkg::SKIP_NEG;
            12'd2:   skip_cond = acc_cpu_pkg::SKIP_ZERO;
            12'd4:   skip_cond = acc_cpu_pkg::SKIP_POS;
            default: skip_cond = acc_cpu_pkg::SKIP_NONE;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = acc_cpu_pkg::ALU_PASS_ACC;
        case (state)
            acc_cpu_pkg::ST_DECODE: begin
                ctrl.ir_we = 1'b1; // IR takes the word fetched last cycle
                ctrl.pc_we = 1'b1;
            end
            acc_cpu_pkg::ST_OPERAND: ctrl.mar_we = 1'b1;
            acc_cpu_pkg::ST_EXECUTE: begin
                ctrl.mbr_we = 1'b1;
                ctrl.acc_we = 1'b1; // Cleared below for non-ALU opcodes
                case (status.opcode)
                    acc_cpu_pkg::OP_LOAD:  ctrl.alu_op = acc_cpu_pkg::ALU_PASS_MEM;
                    acc_cpu_pkg::OP_CLEAR: ctrl.alu_op = acc_cpu_pkg::ALU_ZERO;
                    acc_cpu_pkg::OP_ADD:   ctrl.alu_op = acc_cpu_pkg::ALU_ADD;
                    acc_cpu_pkg::OP_SUB:   ctrl.alu_op = acc_cpu_pkg::ALU_SUB;
                    acc_cpu_pkg::OP_AND:   ctrl.alu_op = acc_cpu_pkg::ALU_AND;
                    acc_cpu_pkg::OP_OR:    ctrl.alu_op = acc_cpu_pkg::ALU_OR;
                    acc_cpu_pkg::OP_XOR:   ctrl.alu_op = acc_cpu_pkg::ALU_XOR;
                    acc_cpu_pkg::OP_SHL:   ctrl.alu_op = acc_cpu_pkg::ALU_SHL;
                    acc_cpu_pkg::OP_SHR:   ctrl.alu_op = acc_cpu_pkg::ALU_SHR;
                    acc_cpu_pkg::OP_ROL:   ctrl.alu_op = acc_cpu_pkg::ALU_ROL;
                    acc_cpu_pkg::OP_ROR:   ctrl.alu_op = acc_cpu_pkg::ALU_ROR;
                    acc_cpu_pkg::OP_STORE: begin
                        ctrl.acc_we  = 1'b0;
                        ctrl.dmem_we = 1'b1; // Accumulator to data memory at the MAR
                    end
                    acc_cpu_pkg::OP_SKIP: begin
                        ctrl.acc_we  = 1'b0;
                        ctrl.pc_skip = status.cond_met; // Taken skip steps over one word
                    end
                    acc_cpu_pkg::OP_JUMP: begin
                        ctrl.acc_we  = 1'b0;
                        ctrl.pc_we   = 1'b1;
                        ctrl.pc_jump = 1'b1;
                    end
                    default: ctrl.acc_we = 1'b0; // HALT and ILLEGAL
                endcase
            end
            default: ; // FETCH only presents the PC
        endcase
    end

    assign store_valid = in_execute && (status.opcode == acc_cpu_pkg::OP_STORE);
    assign halted      = (state == acc_cpu_pkg::ST_HALTED);

    a_state_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot({state == acc_cpu_pkg::ST_IDLE, state == acc_cpu_pkg::ST_FETCH,
                 state == acc_cpu_pkg::ST_DECODE, state == acc_cpu_pkg::ST_OPERAND,
                 state == acc_cpu_pkg::ST_EXECUTE, state == acc_cpu_pkg::ST_HALTED}));

    a_store_no_acc: assert property (@(posedge clock) disable iff (reset)
        !(ctrl.dmem_we && ctrl.acc_we));

    a_quiet_when_stopped: assert property (@(posedge clock) disable iff (reset)
        (state == acc_cpu_pkg::ST_IDLE || halted) |->
        !(ctrl.ir_we || ctrl.pc_we || ctrl.mar_we || ctrl.mbr_we ||
          ctrl.acc_we || ctrl.dmem_we || ctrl.pc_skip));

endmodule

`default_nettype wire

//--- hw/acc_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module acc_cpu #(
    parameter int ADDR_W = 8
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               run,
    input  logic               load_en,
    input  logic               load_imem, // 1 for instruction memory
    input  logic [ADDR_W-1:0]  load_addr,
    input  acc_cpu_pkg::word_t load_data,
    output logic               store_valid,
    output logic [ADDR_W-1:0]  store_addr,
    output acc_cpu_pkg::word_t store_data,
    output acc_cpu_pkg::word_t acc,
    output logic               halted,
    output logic               illegal
);

    acc_cpu_pkg::ctrl_t      ctrl;
    acc_cpu_pkg::dp_status_t status;
    acc_cpu_pkg::skip_cond_e skip_cond;
    acc_cpu_pkg::word_t      imem_data;
    acc_cpu_pkg::word_t      dmem_data;
    acc_cpu_pkg::word_t      dmem_wdata;
    logic [ADDR_W-1:0]       pc;
    logic [ADDR_W-1:0]       mar;
    logic [ADDR_W-1:0]       imem_addr;
    logic [ADDR_W-1:0]       dmem_addr;
    logic                    imem_we;
    logic                    dmem_we;

    // Loader owns both memories while run is low
    assign imem_addr  = run ? pc : load_addr;
    assign imem_we    = !run && load_en && load_imem; // Core never writes code
    assign dmem_addr  = run ? mar : load_addr;
    assign dmem_we    = run ? ctrl.dmem_we : (load_en && !load_imem);
    assign dmem_wdata = run ? acc : load_data;

    assign store_addr = mar; // MAR holds the operand in execute
    assign store_data = acc;

    acc_control u_control (
        .clock       (clock),
        .reset       (reset),
        .run         (run),
        .status      (status),
        .ctrl        (ctrl),
        .skip_cond   (skip_cond),
        .store_valid (store_valid),
        .halted      (halted),
        .illegal     (illegal)
    );

    acc_datapath #(.ADDR_W(ADDR_W)) u_datapath (
        .clock     (clock),
        .reset     (reset),
        .ctrl      (ctrl),
        .skip_cond (skip_cond),
        .imem_data (imem_data),
        .dmem_data (dmem_data),
        .pc        (pc),
        .mar       (mar),
        .acc       (acc),
        .status    (status)
    );

    word_memory #(.ADDR_W(ADDR_W)) u_imem (
        .clock (clock),
        .addr  (imem_addr),
        .we    (imem_we),
        .wdata (load_data),
        .rdata (imem_data)
    );

    word_memory #(.ADDR_W(ADDR_W)) u_dmem (
        .clock (clock),
        .addr  (dmem_addr),
        .we    (dmem_we),
        .wdata (dmem_wdata),
        .rdata (dmem_data)
    );

    // A load while the core runs would race the FSM for the memory ports
    a_load_when_stopped: assert property (@(posedge clock) disable iff (reset)
        load_en |-> !run);

endmodule

`default_nettype wire

//--- hw/acc_cpu_pkg.sv
`default_nettype none

package acc_cpu_pkg;

    localparam int WORD_W    = 16; // Data and instruction word
    localparam int OPERAND_W = 12; // Low field of an instruction

    typedef logic [WORD_W-1:0] word_t;

    // Instruction opcodes, top four bits of the word
    typedef enum logic [3:0] {
        OP_ADD     = 4'd0,
        OP_HALT    = 4'd1,
        OP_LOAD    = 4'd2,
        OP_STORE   = 4'd3,
        OP_CLEAR   = 4'd4,
        OP_SKIP    = 4'd5,
        OP_JUMP    = 4'd6,
        OP_SUB     = 4'd7,
        OP_AND     = 4'd8,
        OP_OR      = 4'd9,
        OP_XOR     = 4'd10,
        OP_SHL     = 4'd11,
        OP_SHR     = 4'd12,
        OP_ROL     = 4'd13,
        OP_ROR     = 4'd14,
        OP_ILLEGAL = 4'd15
    } isa_op_e;

    typedef enum logic [3:0] {
        ALU_PASS_ACC, ALU_ZERO, ALU_PASS_MEM,
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_NAND, // Not reached by the ISA
        ALU_SHL, ALU_SHR, ALU_ROL, ALU_ROR
    } alu_op_e;

    typedef enum logic [1:0] {
        SKIP_NEG,  // Operand 0
        SKIP_ZERO, // Operand 2
        SKIP_POS,  // Operand 4
        SKIP_NONE  // Anything else, never taken
    } skip_cond_e;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_OPERAND, ST_EXECUTE, ST_HALTED
    } cpu_state_e;

    typedef struct packed {
        logic    ir_we;
        logic    pc_we;
        logic    mar_we;
        logic    mbr_we;
        logic    acc_we;
        logic    dmem_we;
        logic    pc_jump;  // Operand replaces the incremented PC
        logic    pc_skip;  // Second increment of a taken skip
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        isa_op_e              opcode;
        logic [OPERAND_W-1:0] operand;
        logic                 cond_met; // Skip test from the ALU
    } dp_status_t;

endpackage

`default_nettype wire

//--- hw/acc_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module acc_datapath #(
    parameter int ADDR_W = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  acc_cpu_pkg::ctrl_t      ctrl,
    input  acc_cpu_pkg::skip_cond_e skip_cond,
    input  acc_cpu_pkg::word_t      imem_data,
    input  acc_cpu_pkg::word_t      dmem_data,
    output logic [ADDR_W-1:0]       pc,
    output logic [ADDR_W-1:0]       mar,
    output acc_cpu_pkg::word_t      acc,
    output acc_cpu_pkg::dp_status_t status
);

    acc_cpu_pkg::word_t ir_q;
    acc_cpu_pkg::word_t mbr_q;
    acc_cpu_pkg::word_t mem_val;
    acc_cpu_pkg::word_t alu_result;
    logic [ADDR_W-1:0]  mar_q;
    logic [ADDR_W-1:0]  operand_addr;
    logic [ADDR_W-1:0]  pc_next;
    logic               cond_met;

    assign operand_addr = ir_q[ADDR_W-1:0]; // Operand cut to the memory depth

    // Jump target or one more word, PC wraps at the memory size
    assign pc_next = ctrl.pc_jump ? operand_addr : pc + ADDR_W'(1);

    // Address goes to the data memory in the cycle the MAR loads
    assign mar = ctrl.mar_we ? operand_addr : mar_q;

    // Same bypass on the MBR so the ALU sees this cycle's read
    assign mem_val = ctrl.mbr_we ? dmem_data : mbr_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc    <= '0;
            ir_q  <= '0;
            mar_q <= '0;
            mbr_q <= '0;
            acc   <= '0;
        end else begin
            if (ctrl.pc_we || ctrl.pc_skip) begin // Skip adds on top of the decode step
                pc <= pc_next;
            end
            if (ctrl.ir_we) begin
                ir_q <= imem_data;
            end
            if (ctrl.mar_we) begin
                mar_q <= operand_addr;
            end
            if (ctrl.mbr_we) begin
                mbr_q <= dmem_data;
            end
            if (ctrl.acc_we) begin
                acc <= alu_result;
            end
        end
    end

    acc_alu u_alu (
        .op        (ctrl.alu_op),
        .acc_val   (acc),
        .mem_val   (mem_val),
        .skip_cond (skip_cond),
        .result    (alu_result),
        .cond_met  (cond_met)
    );

    assign status = '{
        opcode:   acc_cpu_pkg::isa_op_e'(ir_q[15:12]),
        operand:  ir_q[acc_cpu_pkg::OPERAND_W-1:0],
        cond_met: cond_met
    };

endmodule

`default_nettype wire

//--- hw/word_memory.sv
`timescale 1ns/1ps
`default_nettype none

module word_memory #(
    parameter int ADDR_W = 8
) (
    input  logic               clock,
    input  logic [ADDR_W-1:0]  addr,
    input  logic               we,
    input  acc_cpu_pkg::word_t wdata,
    output acc_cpu_pkg::word_t rdata
);

    localparam int DEPTH = 2 ** ADDR_W; // Word addressed

    acc_cpu_pkg::word_t mem [DEPTH];

    always_ff @(posedge clock) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // Old data on a same-cycle write
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run the accumulator CPU testbench
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert \
        --top-module tb_acc_cpu -Mdir obj_dir -f vlog.f \
    && ./obj_dir/Vtb_acc_cpu \
    || { echo "Build or simulation failed" >&2; exit 1; }

//--- sim/tb_acc_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_acc_cpu;

    localparam int ADDR_W       = 8;
    localparam int PROG_LEN     = 8;
    localparam int MAX_STORES   = 4;
    localparam int PROG_IDX_W   = $clog2(PROG_LEN);
    localparam int ST_IDX_W     = $clog2(MAX_STORES);
    localparam int NUM_ROWS     = 17;
    localparam int RESET_CYCLES = 16;
    localparam int LOAD_CYCLES  = PROG_LEN + 2; // Program plus two data words
    localparam int CYCLE_LIMIT  = NUM_ROWS * (RESET_CYCLES + LOAD_CYCLES + 4 * PROG_LEN + 50);
    localparam logic [31:0] RAND_SEED = 32'h2057_9a72;
    localparam logic [11:0] DATA_A    = 12'h040; // Data word slots
    localparam logic [11:0] DATA_B    = 12'h041;

    localparam acc_cpu_pkg::isa_op_e ALU_OPS [9] = '{
        acc_cpu_pkg::OP_ADD, acc_cpu_pkg::OP_SUB, acc_cpu_pkg::OP_AND,
        acc_cpu_pkg::OP_OR,  acc_cpu_pkg::OP_XOR, acc_cpu_pkg::OP_SHL,
        acc_cpu_pkg::OP_SHR, acc_cpu_pkg::OP_ROL, acc_cpu_pkg::OP_ROR
    };

    typedef struct packed {
        acc_cpu_pkg::word_t [0:PROG_LEN-1]   prog;     // Index 0 is address 0
        acc_cpu_pkg::word_t [1:0]            data;     // At DATA_A and DATA_B
        int                                  n_stores;
        logic [MAX_STORES-1:0][ADDR_W-1:0]   st_addr;  // Expected pulses in order
        acc_cpu_pkg::word_t [MAX_STORES-1:0] st_data;
        acc_cpu_pkg::word_t                  exp_acc;  // Accumulator once halted
        logic                                exp_halted;
        logic                                exp_illegal;
    } test_row_t;

    logic               clock;
    logic               reset;
    logic               run;
    logic               load_en;
    logic               load_imem;
    logic [ADDR_W-1:0]  load_addr;
    acc_cpu_pkg::word_t load_data;
    logic               store_valid;
    logic [ADDR_W-1:0]  store_addr;
    acc_cpu_pkg::word_t store_data;
    acc_cpu_pkg::word_t acc;
    logic               halted;
    logic               illegal;

    test_row_t rows [NUM_ROWS];
    string     row_names [NUM_ROWS];
    int        row_count;
    int        cycle_count = 0;

    acc_cpu #(.ADDR_W(ADDR_W)) acc_cpu_inst (
        .clock       (clock),
        .reset       (reset),
        .run         (run),
        .load_en     (load_en),
        .load_imem   (load_imem),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .acc         (acc),
        .halted      (halted),
        .illegal     (illegal)
    );

    always #5 clock = ~clock; // 10 ns period

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("TEST FAIL");
            $fatal(1, "Timeout after %0d cycles, the core did not halt", cycle_count);
        end
    end

    function automatic acc_cpu_pkg::word_t instr(acc_cpu_pkg::isa_op_e op,
                                                 logic [11:0] operand);
        return {op, operand}; // Opcode on top, operand below
    endfunction

    // Accumulator result of each ISA operation
    function automatic acc_cpu_pkg::word_t alu_rule(acc_cpu_pkg::isa_op_e op,
                                                    acc_cpu_pkg::word_t a,
                                                    acc_cpu_pkg::word_t b);
        case (op)
            acc_cpu_pkg::OP_ADD: return a + b; // Wraps at 16 bits
            acc_cpu_pkg::OP_SUB: return a - b;
            acc_cpu_pkg::OP_AND: return a & b;
            acc_cpu_pkg::OP_OR:  return a | b;
            acc_cpu_pkg::OP_XOR: return a ^ b;
            acc_cpu_pkg::OP_SHL: return a << 1;
            acc_cpu_pkg::OP_SHR: return a >> 1; // Zero fill
            acc_cpu_pkg::OP_ROL: return (a << 1) | (a >> 15);
            acc_cpu_pkg::OP_ROR: return (a >> 1) | (a << 15);
            default:             return a;
        endcase
    endfunction

    function automatic test_row_t blank_row();
        test_row_t r;
        r = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            r.prog[PROG_IDX_W'(i)] = instr(acc_cpu_pkg::OP_HALT, 12'h000); // HALT padding
        end
        r.exp_halted = 1'b1;
        return r;
    endfunction

    function automatic test_row_t add_store(test_row_t r, logic [ADDR_W-1:0] addr,
                                            acc_cpu_pkg::word_t value);
        r.st_addr[ST_IDX_W'(r.n_stores)] = addr;
        r.st_data[ST_IDX_W'(r.n_stores)] = value;
        r.n_stores++;
        return r;
    endfunction

    task automatic word_check(string test, string what, acc_cpu_pkg::word_t exp,
                              acc_cpu_pkg::word_t act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %04h actual %04h", test, what, exp, act);
            $display("TEST FAIL");
            $fatal(1, "Word mismatch");
        end
    endtask

    task automatic addr_check(string test, string what, logic [ADDR_W-1:0] exp,
                              logic [ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %02h actual %02h", test, what, exp, act);
            $display("TEST FAIL");
            $fatal(1, "Address mismatch");
        end
    endtask

    task automatic flag_check(string test, string what, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error: %s %s expected %0b actual %0b", test, what, exp, act);
            $display("TEST FAIL");
            $fatal(1, "Flag mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1; // Drive and sample just after the edge
    endtask

    task automatic add_row(string name, test_row_t r);
        rows[row_count]      = r;
        row_names[row_count] = name;
        row_count++;
    endtask

    task automatic build_rows();
        test_row_t             r;
        acc_cpu_pkg::isa_op_e  op;
        acc_cpu_pkg::word_t    a;
        acc_cpu_pkg::word_t    b;
        acc_cpu_pkg::word_t    neg;
        acc_cpu_pkg::word_t    pos;
        acc_cpu_pkg::word_t    h;
        logic [ADDR_W-1:0]     st;
        row_count = 0;
        h         = instr(acc_cpu_pkg::OP_HALT, 12'h000);
        r         = blank_row();
        add_row("halt_only", r); // No stores at all
        for (int i = 0; i < 9; i++) begin
            op = ALU_OPS[i];
            a  = acc_cpu_pkg::word_t'($urandom);
            b  = acc_cpu_pkg::word_t'($urandom);
            st = ADDR_W'($urandom) | ADDR_W'(8'h80); // Stores land above the data words
            r  = blank_row();
            r.prog[0] = instr(acc_cpu_pkg::OP_LOAD, DATA_A);
            r.prog[1] = instr(op, DATA_B);
            r.prog[2] = instr(acc_cpu_pkg::OP_STORE, 12'(st));
            r.data    = {b, a};
            r.exp_acc = alu_rule(op, a, b);
            r         = add_store(r, st, r.exp_acc);
            add_row($sformatf("alu_%s", op.name()), r);
        end
        a   = acc_cpu_pkg::word_t'($urandom) | 16'h0001; // Never zero
        neg = acc_cpu_pkg::word_t'($urandom) | 16'h8000;
        pos = (acc_cpu_pkg::word_t'($urandom) & 16'h7fff) | 16'h0001;
        r = blank_row();
        r.prog = {instr(acc_cpu_pkg::OP_LOAD, DATA_A), instr(acc_cpu_pkg::OP_CLEAR, 12'h000),
                  instr(acc_cpu_pkg::OP_STORE, 12'h091), h, h, h, h, h};
        r.data = {16'h0000, a};
        r      = add_store(r, 8'h91, 16'h0000);
        add_row("clear_store", r);
        // Marker at 0x90 follows each taken skip
        r = blank_row();
        r.prog = {instr(acc_cpu_pkg::OP_LOAD, DATA_A), instr(acc_cpu_pkg::OP_SKIP, 12'd0),
                  instr(acc_cpu_pkg::OP_STORE, 12'h090), instr(acc_cpu_pkg::OP_STORE, 12'h091),
                  instr(acc_cpu_pkg::OP_SKIP, 12'd4), instr(acc_cpu_pkg::OP_STORE, 12'h092),
                  h, h};
        r.data    = {16'h0000, neg};
        r.exp_acc = neg;
        r         = add_store(add_store(r, 8'h91, neg), 8'h92, neg);
        add_row("skip_negative", r);
        r = blank_row();
        r.prog = {instr(acc_cpu_pkg::OP_CLEAR, 12'h000), instr(acc_cpu_pkg::OP_SKIP, 12'd2),
                  instr(acc_cpu_pkg::OP_STORE, 12'h090), instr(acc_cpu_pkg::OP_SKIP, 12'd0),
                  instr(acc_cpu_pkg::OP_STORE, 12'h091), instr(acc_cpu_pkg::OP_SKIP, 12'd4),
                  instr(acc_cpu_pkg::OP_STORE, 12'h092), h};
        r = add_store(add_store(r, 8'h91, 16'h0000), 8'h92, 16'h0000);
        add_row("skip_zero", r);
        r = blank_row();
        r.prog = {instr(acc_cpu_pkg::OP_LOAD, DATA_B), instr(acc_cpu_pkg::OP_SKIP, 12'd4),
                  instr(acc_cpu_pkg::OP_STORE, 12'h090), instr(acc_cpu_pkg::OP_SKIP, 12'd2),
                  instr(acc_cpu_pkg::OP_STORE, 12'h091), instr(acc_cpu_pkg::OP_SKIP, 12'd3),
                  instr(acc_cpu_pkg::OP_STORE, 12'h092), h}; // Operand 3 is no condition
        r.data    = {pos, 16'h0000};
        r.exp_acc = pos;
        r         = add_store(add_store(r, 8'h91, pos), 8'h92, pos);
        add_row("skip_positive", r);
        r = blank_row();
        r.prog = {instr(acc_cpu_pkg::OP_LOAD, DATA_A), instr(acc_cpu_pkg::OP_JUMP, 12'd3),
                  instr(acc_cpu_pkg::OP_STORE, 12'h090), instr(acc_cpu_pkg::OP_STORE, 12'h091),
                  h, h, h, h};
        r.data    = {16'h0000, a};
        r.exp_acc = a;
        r         = add_store(r, 8'h91, a);
        add_row("jump_forward", r);
        r = blank_row();
        r.prog = {instr(acc_cpu_pkg::OP_JUMP, 12'd2), h, instr(acc_cpu_pkg::OP_LOAD, DATA_A),
                  instr(acc_cpu_pkg::OP_STORE, 12'h091), instr(acc_cpu_pkg::OP_JUMP, 12'd1),
                  h, h, h}; // Back to the HALT at 1
        r.data    = {16'h0000, a};
        r.exp_acc = a;
        r         = add_store(r, 8'h91, a);
        add_row("jump_backward", r);
        r = blank_row();
        r.prog = {instr(acc_cpu_pkg::OP_LOAD, DATA_A), instr(acc_cpu_pkg::OP_STORE, 12'h091),
                  instr(acc_cpu_pkg::OP_ILLEGAL, 12'h000), instr(acc_cpu_pkg::OP_STORE, 12'h092),
                  h, h, h, h};
        r.data        = {16'h0000, a};
        r.exp_acc     = a;
        r.exp_illegal = 1'b1;
        r             = add_store(r, 8'h91, a);
        add_row("illegal_opcode", r);
    endtask

    task automatic load_word(logic to_imem, logic [ADDR_W-1:0] addr,
                             acc_cpu_pkg::word_t value);
        load_en   = 1'b1;
        load_imem = to_imem;
        load_addr = addr;
        load_data = value;
        next_cycle();
        load_en = 1'b0;
    endtask

    task automatic run_row(int n);
        test_row_t row;
        string     name;
        int        seen;
        row     = rows[n];
        name    = row_names[n];
        reset   = 1'b1;
        run     = 1'b0;
        load_en = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
        flag_check(name, "store_valid after reset", 1'b0, store_valid);
        flag_check(name, "halted after reset", 1'b0, halted);
        flag_check(name, "illegal after reset", 1'b0, illegal);
        word_check(name, "acc after reset", 16'h0000, acc);
        for (int i = 0; i < PROG_LEN; i++) begin
            load_word(1'b1, ADDR_W'(i), row.prog[PROG_IDX_W'(i)]);
        end
        load_word(1'b0, ADDR_W'(DATA_A), row.data[0]);
        load_word(1'b0, ADDR_W'(DATA_B), row.data[1]);
        run  = 1'b1;
        seen = 0;
        while (halted !== 1'b1) begin
            next_cycle();
            if (store_valid === 1'b1 && seen >= row.n_stores) begin
                $display("TEST FAIL");
                $fatal(1, "%s: extra store pulse to address %02h", name, store_addr);
            end else if (store_valid === 1'b1) begin
                addr_check(name, "store_addr", row.st_addr[ST_IDX_W'(seen)], store_addr);
                word_check(name, "store_data", row.st_data[ST_IDX_W'(seen)], store_data);
                seen++;
            end
        end
        if (seen != row.n_stores) begin
            $display("TEST FAIL");
            $fatal(1, "%s: %0d of %0d store pulses before halt", name, seen, row.n_stores);
        end else begin
            flag_check(name, "illegal", row.exp_illegal, illegal);
            word_check(name, "final acc", row.exp_acc, acc);
            next_cycle();
            flag_check(name, "halted held", row.exp_halted, halted); // Level, not a pulse
            flag_check(name, "store_valid while halted", 1'b0, store_valid);
            run = 1'b0;
        end
    endtask

    initial begin
        clock     = 1'b0;
        reset     = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_imem = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(RAND_SEED));
        build_rows();
        for (int n = 0; n < row_count; n++) begin
            run_row(n);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/acc_cpu_pkg.sv
hw/acc_alu.sv
hw/word_memory.sv
hw/acc_datapath.sv
hw/acc_control.sv
hw/acc_cpu.sv
sim/tb_acc_cpu.sv
